/* logic/i2c_ctrl_pkg.sv */
`default_nettype none

package i2c_ctrl_pkg;

  typedef logic [6:0]  dev_addr_t;
  typedef logic [7:0]  i2c_byte_t;
  typedef logic [3:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  wr_len_t;

  // Register map
  localparam axil_addr_t REG_FILTER = 4'h0;
  localparam axil_addr_t REG_CMD    = 4'h4;
  localparam axil_addr_t REG_RDATA  = 4'h8;
  localparam axil_addr_t REG_STATUS = 4'hc;

  // Status word bits
  localparam int ST_BUSY     = 0;
  localparam int ST_MISSED   = 1;
  localparam int ST_NACK     = 2;
  localparam int ST_FILT_LSB = 8;

  localparam int CMD_READ_BIT = 24;

  localparam dev_addr_t FILTER_DEV = 7'h20;
  localparam i2c_byte_t FILTER_REG = 8'h0a;
  localparam int        RD_BYTES   = 4;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* logic/axil_cmd_port.sv */
`default_nettype none

module axil_cmd_port (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     awvalid_i,
  output logic                          awready_o,
  input  wire i2c_ctrl_pkg::axil_addr_t awaddr_i,
  input  wire logic                     wvalid_i,
  output logic                          wready_o,
  input  wire i2c_ctrl_pkg::axil_data_t wdata_i,
  output logic                          bvalid_o,
  input  wire logic                     bready_i,
  output logic [1:0]                    bresp_o,
  input  wire logic                     arvalid_i,
  output logic                          arready_o,
  input  wire i2c_ctrl_pkg::axil_addr_t araddr_i,
  output logic                          rvalid_o,
  input  wire logic                     rready_i,
  output i2c_ctrl_pkg::axil_data_t      rdata_o,
  output logic [1:0]                    rresp_o,
  output logic                          cmd_go_o,
  output i2c_ctrl_pkg::axil_data_t      cmd_word_o,
  output logic                          filter_go_o,
  output logic [6:0]                    filter_val_o,
  input  wire logic                     seq_busy_i,
  input  wire logic                     flt_busy_i,
  input  wire logic                     seq_nack_i,
  input  wire i2c_ctrl_pkg::axil_data_t rdata_i,
  input  wire logic                     rdata_we_i,
  input  wire logic [6:0]               filter_i
);

  import i2c_ctrl_pkg::*;

  logic       wr_hs;
  logic       rd_hs;
  logic       cmd_wr;
  logic       missed;
  logic       missed_q;
  logic       nack_q;
  axil_data_t rdata_q;
  axil_data_t status;
  axil_data_t rd_mux;

  assign wr_hs     = awvalid_i && wvalid_i && !bvalid_o;
  assign awready_o = wr_hs;
  assign wready_o  = wr_hs;
  assign rd_hs     = arvalid_i && !rvalid_o;
  assign arready_o = !rvalid_o;
  assign rresp_o   = RESP_OKAY;

  // Sequencer counts as busy in the cycle its go pulse is out
  assign cmd_wr = wr_hs && (awaddr_i == REG_CMD);
  assign missed = cmd_wr && (seq_busy_i || cmd_go_o);

  always_comb begin
    status                   = '0;
    status[ST_BUSY]          = seq_busy_i || flt_busy_i;
    status[ST_MISSED]        = missed_q;
    status[ST_NACK]          = nack_q;
    status[ST_FILT_LSB +: 7] = filter_i;
  end

  always_comb begin
    case (araddr_i)
      REG_FILTER: rd_mux = {25'd0, filter_i};
      REG_RDATA:  rd_mux = rdata_q;
      REG_STATUS: rd_mux = status;
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid_o    <= 1'b0;
      rvalid_o    <= 1'b0;
      cmd_go_o    <= 1'b0;
      filter_go_o <= 1'b0;
      missed_q    <= 1'b0;
      nack_q      <= 1'b0;
      rdata_q     <= '0;
    end else begin
      cmd_go_o    <= cmd_wr && !missed;
      filter_go_o <= wr_hs && (awaddr_i == REG_FILTER);
      if (wr_hs) begin
        bvalid_o <= 1'b1;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
      if (rd_hs) begin
        rvalid_o <= 1'b1;
      end else if (rready_i) begin
        rvalid_o <= 1'b0;
      end
      // Sticky bits clear on a status read, a new event wins
      if (rd_hs && (araddr_i == REG_STATUS)) begin
        missed_q <= 1'b0;
        nack_q   <= 1'b0;
      end
      if (missed) begin
        missed_q <= 1'b1;
      end
      if (seq_nack_i) begin
        nack_q <= 1'b1;
      end
      if (rdata_we_i) begin
        rdata_q <= rdata_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      bresp_o      <= missed ? RESP_SLVERR : RESP_OKAY;
      cmd_word_o   <= wdata_i;
      filter_val_o <= wdata_i[6:0];
    end
    if (rd_hs) begin
      rdata_o <= rd_mux;
    end
  end

endmodule

`default_nettype wire

/* logic/i2c_cmd_seq.sv */
`default_nettype none

module i2c_cmd_seq (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     cmd_go_i,
  input  wire i2c_ctrl_pkg::axil_data_t cmd_word_i,
  input  wire logic                     done_i,
  input  wire logic                     nack_i,
  input  wire i2c_ctrl_pkg::axil_data_t rd_data_i,
  output logic                          req_o,
  output i2c_ctrl_pkg::dev_addr_t       dev_o,
  output logic                          read_o,
  output i2c_ctrl_pkg::wr_len_t         len_o,
  output logic [23:0]                   data_o,
  output logic                          busy_o,
  output logic                          nack_o,
  output i2c_ctrl_pkg::axil_data_t      rdata_o,
  output logic                          rdata_we_o
);

  import i2c_ctrl_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WRITE,
    S_READ
  } seq_state_t;

  seq_state_t state;
  logic       rd_cmd_q;
  dev_addr_t  dev_q;
  i2c_byte_t  reg_q;
  i2c_byte_t  val_q;

  assign req_o  = (state != S_IDLE);
  assign dev_o  = dev_q;
  assign read_o = (state == S_READ);
  // Pointer write of a read command carries the register byte only
  assign len_o  = rd_cmd_q ? 2'd1 : 2'd2;
  assign data_o = {reg_q, val_q, 8'h00};

  // Stay busy until the result pulses have reached the port
  assign busy_o = req_o || nack_o || rdata_we_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      nack_o     <= 1'b0;
      rdata_we_o <= 1'b0;
    end else begin
      nack_o     <= 1'b0;
      rdata_we_o <= 1'b0;
      case (state)
        S_IDLE: begin
          if (cmd_go_i) begin
            state <= S_WRITE;
          end
        end
        S_WRITE: begin
          if (done_i) begin
            if (nack_i) begin
              nack_o <= 1'b1;
              state  <= S_IDLE;
            end else if (rd_cmd_q) begin
              state <= S_READ;
            end else begin
              state <= S_IDLE;
            end
          end
        end
        S_READ: begin
          if (done_i) begin
            nack_o     <= nack_i;
            rdata_we_o <= !nack_i;
            state      <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == S_IDLE) && cmd_go_i) begin
      dev_q    <= cmd_word_i[22:16];
      rd_cmd_q <= cmd_word_i[CMD_READ_BIT];
      reg_q    <= cmd_word_i[15:8];
      val_q    <= cmd_word_i[7:0];
    end
    if ((state == S_READ) && done_i) begin
      rdata_o <= rd_data_i;
    end
  end

endmodule

`default_nettype wire

/* logic/filter_sel_sync.sv */
`default_nettype none

module filter_sel_sync (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               filter_go_i,
  input  wire logic [6:0]         filter_val_i,
  input  wire logic               done_i,
  output logic                    req_o,
  output i2c_ctrl_pkg::dev_addr_t dev_o,
  output i2c_ctrl_pkg::wr_len_t   len_o,
  output logic [23:0]             data_o,
  output logic                    busy_o,
  output logic [6:0]              filter_o
);

  import i2c_ctrl_pkg::*;

  typedef enum logic {
    F_IDLE,
    F_SEND
  } flt_state_t;

  flt_state_t state;
  logic [6:0] sent_q;

  assign req_o  = (state == F_SEND);
  assign dev_o  = FILTER_DEV;
  assign len_o  = 2'd3;
  assign data_o = {FILTER_REG, 1'b0, sent_q, 8'h00};
  // An unsent change counts as busy
  assign busy_o = req_o || (filter_o != sent_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= F_IDLE;
      filter_o <= '0;
      sent_q   <= '0;
    end else begin
      if (filter_go_i) begin
        filter_o <= filter_val_i;
      end
      case (state)
        F_IDLE: begin
          if (filter_o != sent_q) begin
            sent_q <= filter_o;
            state  <= F_SEND;
          end
        end
        F_SEND: begin
          if (done_i) begin
            state <= F_IDLE;
          end
        end
        default: state <= F_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/i2c_engine_arb.sv */
`default_nettype none

module i2c_engine_arb (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    f_req_i,
  input  wire i2c_ctrl_pkg::dev_addr_t f_dev_i,
  input  wire logic                    f_read_i,
  input  wire i2c_ctrl_pkg::wr_len_t   f_len_i,
  input  wire logic [23:0]             f_data_i,
  output logic                         f_done_o,
  input  wire logic                    s_req_i,
  input  wire i2c_ctrl_pkg::dev_addr_t s_dev_i,
  input  wire logic                    s_read_i,
  input  wire i2c_ctrl_pkg::wr_len_t   s_len_i,
  input  wire logic [23:0]             s_data_i,
  output logic                         s_done_o,
  output logic                         s_nack_o,
  output logic                         start_o,
  output i2c_ctrl_pkg::dev_addr_t      dev_o,
  output logic                         read_o,
  output i2c_ctrl_pkg::wr_len_t        len_o,
  output logic [23:0]                  data_o,
  input  wire logic                    done_i,
  input  wire logic                    nack_i
);

  logic busy_q;
  // High when the filter requester owns the engine
  logic owner_q;

  assign dev_o  = owner_q ? f_dev_i : s_dev_i;
  assign read_o = owner_q ? f_read_i : s_read_i;
  assign len_o  = owner_q ? f_len_i : s_len_i;
  assign data_o = owner_q ? f_data_i : s_data_i;

  assign f_done_o = done_i && busy_q && owner_q;
  assign s_done_o = done_i && busy_q && !owner_q;
  // Only the sequencer reports a NACK upward
  assign s_nack_o = nack_i && !owner_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
      start_o <= 1'b0;
    end else begin
      start_o <= 1'b0;
      if (!busy_q) begin
        if (f_req_i || s_req_i) begin
          busy_q  <= 1'b1;
          owner_q <= f_req_i;
          start_o <= 1'b1;
        end
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/i2c_xfer_engine.sv */
`default_nettype none

module i2c_xfer_engine #(
  parameter int CLK_DIV = 4
) (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    start_i,
  input  wire i2c_ctrl_pkg::dev_addr_t dev_addr_i,
  input  wire logic                    read_i,
  input  wire i2c_ctrl_pkg::wr_len_t   wr_len_i,
  input  wire logic [23:0]             wr_data_i,
  input  wire logic                    scl_i,
  input  wire logic                    sda_i,
  output logic                         done_o,
  output logic                         nack_o,
  output i2c_ctrl_pkg::axil_data_t     rd_data_o,
  output logic                         scl_oe_o,
  output logic                         sda_oe_o
);

  import i2c_ctrl_pkg::*;

  localparam int               CNT_W   = $clog2(CLK_DIV) + 1;
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(CLK_DIV - 1);

  typedef enum logic [2:0] {
    E_IDLE,
    E_START,
    E_BIT,
    E_STOP,
    E_DONE
  } eng_state_t;

  eng_state_t       state;
  logic [CNT_W-1:0] cnt;
  logic [1:0]       q;
  logic             tick;
  logic             hold;
  logic [3:0]       bit_cnt;
  logic [2:0]       byte_idx;
  logic [2:0]       last_idx;
  logic             rx;
  logic             ack_fail;
  logic             samp;
  logic             read_q;
  wr_len_t          len_q;
  logic [23:0]      wdata_q;
  i2c_byte_t        sh;
  axil_data_t       rd_q;
  logic             nack_q;

  // Start waits for a free bus
  assign hold     = (state == E_START) && (q == 2'd0) && !(scl_i && sda_i);
  assign tick     = (cnt == CNT_MAX) && !hold;
  assign last_idx = read_q ? 3'(RD_BYTES) : {1'b0, len_q};
  assign rx       = read_q && (byte_idx != 3'd0);
  assign ack_fail = !rx && samp;

  assign done_o    = (state == E_DONE);
  assign nack_o    = nack_q;
  assign rd_data_o = rd_q;

  always_ff @(posedge clk) begin
    if (rst || (state == E_IDLE) || tick) begin
      cnt <= '0;
    end else if (!hold) begin
      cnt <= cnt + 1'b1;
    end
  end

  // Quarter phases: SCL low in 0 and 3, high in 1 and 2
  always_comb begin
    scl_oe_o = 1'b0;
    sda_oe_o = 1'b0;
    case (state)
      E_START: begin
        scl_oe_o = (q == 2'd3);
        sda_oe_o = (q != 2'd0);
      end
      E_BIT: begin
        scl_oe_o = (q == 2'd0) || (q == 2'd3);
        if (bit_cnt != 4'd8) begin
          sda_oe_o = !rx && !sh[7];
        end else begin
          // Master ACK on all read bytes but the last
          sda_oe_o = rx && (byte_idx != last_idx);
        end
      end
      E_STOP: begin
        scl_oe_o = (q == 2'd0);
        sda_oe_o = (q <= 2'd1);
      end
      default: begin
        scl_oe_o = 1'b0;
        sda_oe_o = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= E_IDLE;
      q        <= 2'd0;
      bit_cnt  <= 4'd0;
      byte_idx <= 3'd0;
      nack_q   <= 1'b0;
    end else begin
      if (tick) begin
        q <= q + 2'd1;
      end
      case (state)
        E_IDLE: begin
          if (start_i) begin
            bit_cnt  <= 4'd0;
            byte_idx <= 3'd0;
            nack_q   <= 1'b0;
            state    <= E_START;
          end
        end
        E_START: begin
          if (tick && (q == 2'd3)) begin
            state <= E_BIT;
          end
        end
        E_BIT: begin
          if (tick && (q == 2'd3)) begin
            if (bit_cnt != 4'd8) begin
              bit_cnt <= bit_cnt + 4'd1;
            end else begin
              bit_cnt  <= 4'd0;
              byte_idx <= byte_idx + 3'd1;
              nack_q   <= ack_fail;
              if (ack_fail || (byte_idx == last_idx)) begin
                state <= E_STOP;
              end
            end
          end
        end
        E_STOP: begin
          if (tick && (q == 2'd3)) begin
            state <= E_DONE;
          end
        end
        default: state <= E_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == E_IDLE) && start_i) begin
      sh      <= {dev_addr_i, read_i};
      read_q  <= read_i;
      len_q   <= wr_len_i;
      wdata_q <= wr_data_i;
    end
    if ((state == E_BIT) && tick) begin
      if (q == 2'd2) begin
        samp <= sda_i;
      end
      if (q == 2'd3) begin
        if (bit_cnt != 4'd8) begin
          sh <= {sh[6:0], samp};
        end else begin
          sh      <= wdata_q[23:16];
          wdata_q <= {wdata_q[15:0], 8'h00};
          // First received byte ends up in the low bits
          if (rx) begin
            rd_q <= {sh, rd_q[31:8]};
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/i2c_ctrl_top.sv */
`default_nettype none

module i2c_ctrl_top #(
  parameter int CLK_DIV = 4
) (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     awvalid_i,
  output logic                          awready_o,
  input  wire i2c_ctrl_pkg::axil_addr_t awaddr_i,
  input  wire logic                     wvalid_i,
  output logic                          wready_o,
  input  wire i2c_ctrl_pkg::axil_data_t wdata_i,
  output logic                          bvalid_o,
  input  wire logic                     bready_i,
  output logic [1:0]                    bresp_o,
  input  wire logic                     arvalid_i,
  output logic                          arready_o,
  input  wire i2c_ctrl_pkg::axil_addr_t araddr_i,
  output logic                          rvalid_o,
  input  wire logic                     rready_i,
  output i2c_ctrl_pkg::axil_data_t      rdata_o,
  output logic [1:0]                    rresp_o,
  input  wire logic                     scl_i,
  input  wire logic                     sda_i,
  output logic                          scl_oe_o,
  output logic                          sda_oe_o
);

  import i2c_ctrl_pkg::*;

  logic        cmd_go;
  axil_data_t  cmd_word;
  logic        filter_go;
  logic [6:0]  filter_val;
  logic [6:0]  filter_cur;
  logic        seq_busy;
  logic        seq_nack;
  logic        flt_busy;
  axil_data_t  seq_rdata;
  logic        seq_rdata_we;

  logic        s_req;
  dev_addr_t   s_dev;
  logic        s_read;
  wr_len_t     s_len;
  logic [23:0] s_data;
  logic        s_done;
  logic        s_nack;

  logic        f_req;
  dev_addr_t   f_dev;
  wr_len_t     f_len;
  logic [23:0] f_data;
  logic        f_done;

  logic        eng_start;
  dev_addr_t   eng_dev;
  logic        eng_read;
  wr_len_t     eng_len;
  logic [23:0] eng_data;
  logic        eng_done;
  logic        eng_nack;
  axil_data_t  eng_rdata;

  axil_cmd_port axil_cmd_port_inst (
    .clk          (clk),
    .rst          (rst),
    .awvalid_i    (awvalid_i),
    .awready_o    (awready_o),
    .awaddr_i     (awaddr_i),
    .wvalid_i     (wvalid_i),
    .wready_o     (wready_o),
    .wdata_i      (wdata_i),
    .bvalid_o     (bvalid_o),
    .bready_i     (bready_i),
    .bresp_o      (bresp_o),
    .arvalid_i    (arvalid_i),
    .arready_o    (arready_o),
    .araddr_i     (araddr_i),
    .rvalid_o     (rvalid_o),
    .rready_i     (rready_i),
    .rdata_o      (rdata_o),
    .rresp_o      (rresp_o),
    .cmd_go_o     (cmd_go),
    .cmd_word_o   (cmd_word),
    .filter_go_o  (filter_go),
    .filter_val_o (filter_val),
    .seq_busy_i   (seq_busy),
    .flt_busy_i   (flt_busy),
    .seq_nack_i   (seq_nack),
    .rdata_i      (seq_rdata),
    .rdata_we_i   (seq_rdata_we),
    .filter_i     (filter_cur)
  );

  i2c_cmd_seq i2c_cmd_seq_inst (
    .clk        (clk),
    .rst        (rst),
    .cmd_go_i   (cmd_go),
    .cmd_word_i (cmd_word),
    .done_i     (s_done),
    .nack_i     (s_nack),
    .rd_data_i  (eng_rdata),
    .req_o      (s_req),
    .dev_o      (s_dev),
    .read_o     (s_read),
    .len_o      (s_len),
    .data_o     (s_data),
    .busy_o     (seq_busy),
    .nack_o     (seq_nack),
    .rdata_o    (seq_rdata),
    .rdata_we_o (seq_rdata_we)
  );

  filter_sel_sync filter_sel_sync_inst (
    .clk          (clk),
    .rst          (rst),
    .filter_go_i  (filter_go),
    .filter_val_i (filter_val),
    .done_i       (f_done),
    .req_o        (f_req),
    .dev_o        (f_dev),
    .len_o        (f_len),
    .data_o       (f_data),
    .busy_o       (flt_busy),
    .filter_o     (filter_cur)
  );

  i2c_engine_arb i2c_engine_arb_inst (
    .clk      (clk),
    .rst      (rst),
    .f_req_i  (f_req),
    .f_dev_i  (f_dev),
    .f_read_i (1'b0),
    .f_len_i  (f_len),
    .f_data_i (f_data),
    .f_done_o (f_done),
    .s_req_i  (s_req),
    .s_dev_i  (s_dev),
    .s_read_i (s_read),
    .s_len_i  (s_len),
    .s_data_i (s_data),
    .s_done_o (s_done),
    .s_nack_o (s_nack),
    .start_o  (eng_start),
    .dev_o    (eng_dev),
    .read_o   (eng_read),
    .len_o    (eng_len),
    .data_o   (eng_data),
    .done_i   (eng_done),
    .nack_i   (eng_nack)
  );

  i2c_xfer_engine #(
    .CLK_DIV (CLK_DIV)
  ) i2c_xfer_engine_inst (
    .clk        (clk),
    .rst        (rst),
    .start_i    (eng_start),
    .dev_addr_i (eng_dev),
    .read_i     (eng_read),
    .wr_len_i   (eng_len),
    .wr_data_i  (eng_data),
    .scl_i      (scl_i),
    .sda_i      (sda_i),
    .done_o     (eng_done),
    .nack_o     (eng_nack),
    .rd_data_o  (eng_rdata),
    .scl_oe_o   (scl_oe_o),
    .sda_oe_o   (sda_oe_o)
  );

endmodule

`default_nettype wire

/* sim/i2c_target_model.sv */
`default_nettype none

module i2c_target_model (
  input  wire logic       scl_i,
  input  wire logic       sda_i,
  output logic            sda_oe_o,
  input  wire logic [7:0] peek_addr_i,
  output logic [7:0]      peek_data_o,
  output int              flt_writes_o
);

  logic [7:0] mem [256];
  logic       active = 1'b0;
  logic       addressed = 1'b0;
  logic       rw = 1'b0;
  logic       mnack = 1'b0;
  logic       tx;
  logic       last_scl = 1'b1;
  int         bitn = 0;
  int         byte_cnt = 0;
  logic [7:0] shreg = 8'h00;
  logic [7:0] ptr = 8'h00;
  logic [7:0] tx_byte = 8'h00;

  initial begin
    sda_oe_o     = 1'b0;
    flt_writes_o = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i) ^ 8'h5a;
    end
  end

  assign peek_data_o = mem[peek_addr_i];

  always @(posedge scl_i or negedge scl_i or posedge sda_i or negedge sda_i) begin
    tx = rw && addressed && (byte_cnt != 0);
    if (scl_i === last_scl) begin
      // SDA moved while SCL high is a start or a stop
      if ((scl_i === 1'b1) && (sda_i === 1'b0)) begin
        active    = 1'b1;
        // The SCL fall right after a start is not a bit
        bitn      = -1;
        byte_cnt  = 0;
        addressed = 1'b0;
        rw        = 1'b0;
        mnack     = 1'b0;
        sda_oe_o  = 1'b0;
      end else if ((scl_i === 1'b1) && (sda_i === 1'b1)) begin
        active   = 1'b0;
        sda_oe_o = 1'b0;
      end
    end else if (active && (scl_i === 1'b1)) begin
      if (bitn < 8) begin
        if (!tx) begin
          shreg = {shreg[6:0], sda_i};
        end
      end else if (tx) begin
        mnack = sda_i;
      end
    end else if (active) begin
      if (bitn == 7) begin
        bitn = 8;
        if (tx) begin
          sda_oe_o = 1'b0;
        end else if (byte_cnt == 0) begin
          addressed = (shreg[7:1] == 7'h48) || (shreg[7:1] == 7'h20);
          rw        = shreg[0];
          if (!rw && (shreg[7:1] == 7'h20)) begin
            flt_writes_o = flt_writes_o + 1;
          end
          sda_oe_o = addressed;
        end else if (addressed) begin
          // First data byte sets the register pointer
          if (byte_cnt == 1) begin
            ptr = shreg;
          end else begin
            mem[ptr] = shreg;
            ptr      = ptr + 8'd1;
          end
          sda_oe_o = 1'b1;
        end
      end else if (bitn == 8) begin
        bitn     = 0;
        byte_cnt = byte_cnt + 1;
        if (rw && addressed && !mnack) begin
          tx_byte  = mem[ptr];
          ptr      = ptr + 8'd1;
          sda_oe_o = !tx_byte[7];
        end else begin
          sda_oe_o = 1'b0;
        end
      end else begin
        bitn = bitn + 1;
        if (tx && !mnack) begin
          sda_oe_o = !tx_byte[7 - bitn];
        end
      end
    end
    last_scl = scl_i;
  end

endmodule

`default_nettype wire

/* sim/tb_i2c_ctrl.sv */
`default_nettype none

module tb_i2c_ctrl;

  import i2c_ctrl_pkg::*;

  localparam int CLK_DIV      = 4;
  localparam int MAX_TESTS    = 64;
  localparam int STALL_CYCLES = 6;
  localparam int XFER_BYTES   = 8;
  localparam int MARGIN       = 200;

  logic       clk = 1'b0;
  logic       rst;
  logic       awvalid;
  logic       awready;
  axil_addr_t awaddr;
  logic       wvalid;
  logic       wready;
  axil_data_t wdata;
  logic       bvalid;
  logic       bready;
  logic [1:0] bresp;
  logic       arvalid;
  logic       arready;
  axil_addr_t araddr;
  logic       rvalid;
  logic       rready;
  axil_data_t rdata;
  logic [1:0] rresp;
  logic       scl_oe;
  logic       sda_oe;
  logic       tgt_sda_oe;
  logic       scl_line;
  logic       sda_line;
  logic [7:0] peek_addr;
  logic [7:0] peek_data;
  int         flt_writes;

  axil_data_t gold [4*MAX_TESTS];
  int         ntests;
  logic       loaded = 1'b0;
  int         pass_cnt = 0;
  int         fail_cnt = 0;

  always #5 clk = ~clk;

  // Open-drain lines with pull-ups
  assign scl_line = !scl_oe;
  assign sda_line = !(sda_oe || tgt_sda_oe);

  i2c_ctrl_top #(
    .CLK_DIV (CLK_DIV)
  ) i2c_ctrl_top_inst (
    .clk       (clk),
    .rst       (rst),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .awaddr_i  (awaddr),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .wdata_i   (wdata),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .bresp_o   (bresp),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .araddr_i  (araddr),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rdata_o   (rdata),
    .rresp_o   (rresp),
    .scl_i     (scl_line),
    .sda_i     (sda_line),
    .scl_oe_o  (scl_oe),
    .sda_oe_o  (sda_oe)
  );

  i2c_target_model target_inst (
    .scl_i        (scl_line),
    .sda_i        (sda_line),
    .sda_oe_o     (tgt_sda_oe),
    .peek_addr_i  (peek_addr),
    .peek_data_o  (peek_data),
    .flt_writes_o (flt_writes)
  );

  task automatic axi_write(input axil_addr_t addr, input axil_data_t data, input int stall,
                           output logic [1:0] resp, output logic ok);
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    bready  <= (stall == 0);
    do @(negedge clk); while (!(awready && wready));
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do @(negedge clk); while (!bvalid);
    resp = bresp;
    ok   = 1'b1;
    for (int i = 0; i < stall; i++) begin
      @(negedge clk);
      if (!bvalid || (bresp !== resp)) begin
        ok = 1'b0;
      end
    end
    if (stall != 0) begin
      @(posedge clk);
      bready <= 1'b1;
    end
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input axil_addr_t addr, input int stall,
                          output axil_data_t data, output logic [1:0] resp,
                          output logic ok);
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    rready  <= (stall == 0);
    do @(negedge clk); while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    do @(negedge clk); while (!rvalid);
    data = rdata;
    resp = rresp;
    ok   = 1'b1;
    for (int i = 0; i < stall; i++) begin
      @(negedge clk);
      if (!rvalid || (rdata !== data) || (rresp !== resp)) begin
        ok = 1'b0;
      end
    end
    if (stall != 0) begin
      @(posedge clk);
      rready <= 1'b1;
    end
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // Sticky bits clear on every status read, so collect them over the polls
  task automatic wait_idle(output axil_data_t status);
    axil_data_t v;
    axil_data_t acc;
    logic [1:0] resp;
    logic       ok;
    acc = '0;
    do begin
      axi_read(REG_STATUS, 0, v, resp, ok);
      acc = acc | (v & 32'h6);
    end while (v[ST_BUSY]);
    status = v | acc;
  endtask

  task automatic compare_word(input string name, input axil_data_t exp, input axil_data_t act,
                              inout logic good);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      good = 1'b0;
    end
  endtask

  function automatic string op_name(input axil_data_t op);
    case (op)
      1: return "write";
      2: return "read";
      3: return "missed_cmd";
      4: return "target_reg";
      5: return "filter_count";
      6: return "r_stall";
      7: return "b_stall";
      default: return "unknown";
    endcase
  endfunction

  task automatic run_test(input int idx);
    axil_data_t op;
    axil_data_t addr;
    axil_data_t data;
    axil_data_t exp;
    axil_data_t act;
    logic [1:0] resp;
    logic       ok;
    logic       good;
    string      name;
    op   = gold[4*idx];
    addr = gold[4*idx+1];
    data = gold[4*idx+2];
    exp  = gold[4*idx+3];
    good = 1'b1;
    name = $sformatf("test%0d %s", idx + 1, op_name(op));
    case (op)
      1: begin
        axi_write(addr[3:0], data, 0, resp, ok);
        compare_word({name, " bresp"}, 32'(RESP_OKAY), 32'(resp), good);
        wait_idle(act);
        compare_word({name, " status"}, exp, act, good);
      end
      2: begin
        axi_read(addr[3:0], 0, act, resp, ok);
        compare_word({name, " rresp"}, 32'(RESP_OKAY), 32'(resp), good);
        compare_word(name, exp, act, good);
      end
      3: begin
        axi_write(addr[3:0], data, 0, resp, ok);
        compare_word({name, " first bresp"}, 32'(RESP_OKAY), 32'(resp), good);
        axi_write(addr[3:0], data + 32'd1, 0, resp, ok);
        compare_word({name, " second bresp"}, 32'(RESP_SLVERR), 32'(resp), good);
        wait_idle(act);
        compare_word({name, " status"}, exp, act, good);
      end
      4: begin
        @(posedge clk);
        peek_addr <= addr[7:0];
        @(negedge clk);
        compare_word(name, exp, 32'(peek_data), good);
      end
      5: begin
        compare_word(name, exp, 32'(flt_writes), good);
      end
      6: begin
        axi_read(addr[3:0], STALL_CYCLES, act, resp, ok);
        if (!ok) begin
          $display("%s: rvalid dropped or the read response changed while rready was low",
                   name);
          good = 1'b0;
        end
        compare_word({name, " rresp"}, 32'(RESP_OKAY), 32'(resp), good);
        compare_word(name, exp, act, good);
      end
      7: begin
        axi_write(addr[3:0], data, STALL_CYCLES, resp, ok);
        if (!ok) begin
          $display("%s: bvalid dropped or bresp changed while bready was low", name);
          good = 1'b0;
        end
        compare_word(name, exp, 32'(resp), good);
      end
      default: begin
        $display("%s: the golden file holds an unknown operation code %0d", name, op);
        good = 1'b0;
      end
    endcase
    if (good) begin
      pass_cnt++;
      $display("%s: ok", name);
    end else begin
      fail_cnt++;
      $display("%s: FAILED", name);
    end
  endtask

  initial begin
    rst       <= 1'b1;
    awvalid   <= 1'b0;
    awaddr    <= '0;
    wvalid    <= 1'b0;
    wdata     <= '0;
    bready    <= 1'b0;
    arvalid   <= 1'b0;
    araddr    <= '0;
    rready    <= 1'b0;
    peek_addr <= '0;
    for (int i = 0; i < 4*MAX_TESTS; i++) begin
      gold[i] = '0;
    end
    $readmemh("sim/i2c_ctrl_golden.txt", gold);
    ntests = 0;
    while ((ntests < MAX_TESTS) && (gold[4*ntests] != 0)) begin
      ntests++;
    end
    loaded = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < ntests; i++) begin
      run_test(i);
    end
    @(posedge clk);
    $display("tests: %0d, passed: %0d, failed: %0d", ntests, pass_cnt, fail_cnt);
    if ((fail_cnt == 0) && (ntests > 0)) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Budget per test covers the longest read command plus the polls
  initial begin
    wait (loaded);
    #(longint'(ntests) * (XFER_BYTES * 9 * 4 * CLK_DIV + MARGIN) * 10);
    $display("Timeout: the tests did not finish within the watchdog limit");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/i2c_ctrl_golden.txt */
// Columns: op addr wdata expected
// op 1 write+poll, 2 read, 3 missed cmd, 4 target reg, 5 filter writes, 6 r stall, 7 b stall
1 4 0048105c 00000000
1 4 004811a1 00000000
1 4 00481272 00000000
1 4 0048133e 00000000
1 4 01481000 00000000
2 8 00000000 3e72a15c
1 4 01331000 00000004
2 8 00000000 3e72a15c
2 c 00000000 00000000
3 4 0048207b 00000002
2 c 00000000 00000000
4 20 00000000 0000007b
1 0 00000015 00001500
4 0a 00000000 00000015
4 0b 00000000 00000000
5 0 00000000 00000001
1 0 00000015 00001500
5 0 00000000 00000001
6 8 00000000 3e72a15c
7 0 00000015 00000000

/* filelist.f */
logic/i2c_ctrl_pkg.sv
logic/axil_cmd_port.sv
logic/i2c_cmd_seq.sv
logic/filter_sel_sync.sv
logic/i2c_engine_arb.sv
logic/i2c_xfer_engine.sv
logic/i2c_ctrl_top.sv
sim/i2c_target_model.sv
sim/tb_i2c_ctrl.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      = --binary --timing
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_i2c_ctrl
FILELIST   = filelist.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
